// File: hw/periph_defs.svh
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

//////////////////////
// UART

// Clocks per bit; uartCore also takes it as a parameter default
`define UART_DIVIDER 16

//////////////////////
// PWM

// Terminal count, the counter runs 0..180 (181 steps)
`define PWM_TOP 180

//////////////////////
// Address map blocks, offset bits 7..5

`define BLK_UART  3'd0    // 0x00 data, 0x04 status
`define BLK_PWM   3'd1    // 0x20 duty / gpin
`define BLK_TIMER 3'd3    // 0x60 timer
`define BLK_IRQ   3'd7    // 0xE0 mask, 0xF4..0xFC vectors

// Free-running timer
`define TIMER_W 32

`endif

// File: hw/apbPkg.sv
package apbPkg;

	//////////////////////
	// APB signals, master to slave
	typedef struct packed {
		logic        psel;       // Slave selected
		logic        penable;    // Access phase
		logic        pwrite;     // 1 write, 0 read
		logic [7:0]  paddr;      // Byte offset in the peripheral area
		logic [31:0] pwdata;     // Always a full word
	} apbReq;

	// Slave to master, no PSLVERR
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;     // Low inserts a wait state
	} apbRsp;

	//////////////////////
	// Register offset, two decodings of the same byte

	// UART, PWM, timer and input port
	typedef struct packed {
		logic [2:0] block;
		logic [2:0] word;
		logic [1:0] byteOff;
	} genOffset;

	// Interrupt controller: mask at index 0, vectors when isVector set
	typedef struct packed {
		logic [2:0] block;
		logic       isVector;
		logic [1:0] vecIdx;
		logic [1:0] byteOff;
	} irqOffset;

	typedef union packed {
		genOffset gen;
		irqOffset irq;
	} regOffset;

endpackage

// File: hw/periphPkg.sv
package periphPkg;

	//////////////////////
	// UART status flags
	typedef struct packed {
		logic rxValid;       // Byte waiting in the buffer
		logic txRdy;         // Transmitter idle
		logic rxOverrun;     // Byte lost, buffer overwritten
		logic rxFrameErr;    // Stop bit of the buffered byte was 0
	} uartFlags;

	//////////////////////
	// Interrupt sources
	// Also the layout of the enable mask: bit0 rx, bit1 tx, bit2 PWM
	typedef struct packed {
		logic pwmPeriod;     // Mask bit 2, vector 3, lowest priority
		logic txRdy;         // Mask bit 1, vector 2
		logic rxValid;       // Mask bit 0, vector 1, highest priority
	} irqSources;

endpackage

// File: hw/uartCore.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

// 8N1 UART with fixed baud rate
module uartCore import periphPkg::*; #(
	parameter int clksPerBit = `UART_DIVIDER
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] txData,     // Byte to send
	input  logic       txWrite,    // Starts a transmission
	input  logic       rxRead,     // Clears valid and overrun
	output logic [7:0] rxData,
	output uartFlags   flags,
	input  logic       rxd,
	output logic       txd
);

	localparam int divW = $clog2(clksPerBit);

	//////////////////////
	// Transmitter

	logic [divW-1:0] txDiv;
	logic            txDivMax;
	logic [8:0]      txSh;        // Data plus start bit, LSB first
	logic [3:0]      txBitCnt;    // Bit times left, 0 when idle
	logic            txBusy;

	assign txDivMax = (txDiv == divW'(clksPerBit - 1));
	assign txBusy   = |txBitCnt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) txDiv <= '0;
		else if (txWrite || txDivMax) txDiv <= '0;    // Restart the bit time on a write
		else txDiv <= txDiv + 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txSh <= 9'h1FF;    // Line idles high
		end else if (txWrite) begin
			txSh <= {txData, 1'b0};
		end else if (txDivMax) begin
			txSh <= {1'b1, txSh[8:1]};    // Ones shift in, last one is the stop bit
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) txBitCnt <= '0;
		else if (txWrite) txBitCnt <= 4'd10;    // Start, 8 data, stop
		else if (txBusy && txDivMax) txBitCnt <= txBitCnt - 1'b1;
	end

	assign txd = txSh[0];

	//////////////////////
	// Receiver

	logic [1:0]      rxSync;      // Two-flop synchroniser
	logic [divW-1:0] rxDiv;
	logic            rxSample;
	logic [9:0]      rxSh;        // Start bit lands in bit 0 when the frame is done
	logic            rxDone;
	logic [7:0]      rxBuf;
	logic            rxStop;      // Stop bit of the buffered frame
	logic [1:0]      rxVal;       // 01 valid, 11 valid with overrun

	always_ff @(posedge clk or posedge reset) begin
		if (reset) rxSync <= 2'b11;
		else rxSync <= {rxSync[0], rxd};
	end

	// Bit timer realigns on any line edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) rxDiv <= '0;
		else if ((rxSync[1] ^ rxSync[0]) || rxDiv == divW'(clksPerBit - 1)) rxDiv <= '0;
		else rxDiv <= rxDiv + 1'b1;
	end

	assign rxSample = (rxDiv == divW'(clksPerBit / 2 - 1));    // Mid-bit
	assign rxDone   = ~rxSh[0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) rxSh <= 10'h3FF;
		else if (rxDone) rxSh <= 10'h3FF;    // Frame taken, rearm
		else if (rxSample) rxSh <= {rxSync[1], rxSh[9:1]};
	end

	always_ff @(posedge clk) begin
		if (rxDone) rxBuf <= rxSh[8:1];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) rxStop <= 1'b1;
		else if (rxDone) rxStop <= rxSh[9];
	end

	// New byte beats a read in the same cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) rxVal <= '0;
		else if (rxDone) rxVal <= {rxVal[0], 1'b1};
		else if (rxRead) rxVal <= '0;
	end

	assign rxData           = rxBuf;
	assign flags.rxValid    = rxVal[0];
	assign flags.rxOverrun  = rxVal[1];
	assign flags.rxFrameErr = ~rxStop;
	assign flags.txRdy      = ~txBusy;

endmodule

// File: hw/pwmUnit.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

// PWM with a 181-step period and buffered duty
module pwmUnit (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] duty,
	input  logic       dutyWrite,
	output logic       pwmOut,
	output logic       pwmPeriod    // Set at count 0, cleared by a duty write
);

	logic [7:0] count;
	logic [7:0] dutyReg;
	logic [7:0] dutyBuf;    // Active duty, changes only at the end of a period
	logic       termCnt;
	logic       zeroCnt;

	assign termCnt = (count == 8'(`PWM_TOP));
	assign zeroCnt = (count == 8'd0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count     <= '0;
			dutyReg   <= '0;
			dutyBuf   <= '0;
			pwmOut    <= 1'b0;
			pwmPeriod <= 1'b0;
		end else begin
			count <= termCnt ? 8'd0 : count + 1'b1;
			if (dutyWrite) dutyReg <= duty;
			if (termCnt) dutyBuf <= dutyReg;
			// Compare first, so duty 0 stays low
			if (count == dutyBuf) pwmOut <= 1'b0;
			else if (zeroCnt) pwmOut <= 1'b1;
			if (zeroCnt) pwmPeriod <= 1'b1;
			else if (dutyWrite) pwmPeriod <= 1'b0;
		end
	end

endmodule

// File: hw/irqCtrl.sv
`timescale 1ns/1ps

// Interrupt mask, vector table and fixed-priority select
module irqCtrl import periphPkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] wdata,
	input  logic        irqEnWrite,
	input  logic        vecWrite,
	input  logic [1:0]  vecIndex,     // 1..3, index 0 holds no vector
	input  irqSources   sources,
	output irqSources   enable,
	output logic        irq,
	output logic [29:0] irqVector     // Word address, bits 31..2
);

	logic [29:0] vecTab [1:3];
	irqSources   pending;

	//////////////////////
	// Registers

	always_ff @(posedge clk or posedge reset) begin
		if (reset) enable <= '0;
		else if (irqEnWrite) enable <= wdata[2:0];
	end

	// Vectors keep only the word address
	always_ff @(posedge clk) begin
		if (vecWrite && vecIndex != 2'd0) vecTab[vecIndex] <= wdata[31:2];
	end

	//////////////////////
	// Priority

	assign pending = sources & enable;
	assign irq     = |pending;

	always_comb begin
		if (pending.rxValid) irqVector = vecTab[1];
		else if (pending.txRdy) irqVector = vecTab[2];
		else irqVector = vecTab[3];    // PWM, also shown when idle
	end

endmodule

// File: hw/periphTop.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

// APB peripheral subsystem with UART, PWM, interrupts, timer and input port
module periphTop import apbPkg::*, periphPkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  apbReq       req,
	output apbRsp       rsp,
	input  logic        rxd,
	output logic        txd,
	input  logic [3:0]  gpin,
	output logic        pwmOut,
	output logic        irq,
	output logic [29:0] irqVector
);

	regOffset              off;
	logic                  access;     // Access phase of a transfer
	logic                  done;       // Completing edge
	logic                  aligned;
	logic                  uartData;   // Offset 0x00
	logic                  stall;
	logic                  txWrite, rxRead, dutyWrite, irqEnWrite, vecWrite;
	logic [7:0]            rxData;
	uartFlags              flags;
	logic                  pwmPeriod;
	irqSources             sources;
	irqSources             enable;
	logic [`TIMER_W-1:0]   timer;

	//////////////////////
	// Decode

	assign off      = req.paddr;
	assign access   = req.psel & req.penable;
	assign aligned  = (off.gen.byteOff == 2'b00);
	assign uartData = aligned && off.gen.block == `BLK_UART && off.gen.word == 3'd0;

	// Wait while the transmitter is busy or no byte has arrived
	assign stall = uartData && (req.pwrite ? ~flags.txRdy : ~flags.rxValid);
	assign done  = access & rsp.pready;

	// One-cycle strobes at the completing edge
	assign txWrite    = done & req.pwrite & uartData;
	assign rxRead     = done & ~req.pwrite & uartData;
	assign dutyWrite  = done & req.pwrite & aligned &
		off.gen.block == `BLK_PWM & off.gen.word == 3'd0;
	assign irqEnWrite = done & req.pwrite & aligned & off.irq.block == `BLK_IRQ &
		~off.irq.isVector & off.irq.vecIdx == 2'd0;
	assign vecWrite   = done & req.pwrite & aligned & off.irq.block == `BLK_IRQ &
		off.irq.isVector;

	//////////////////////
	// Read mux

	always_comb begin
		rsp.pready = ~(access & stall);    // Low inserts a wait state
		rsp.prdata = '0;    // Unmapped reads zero
		if (aligned) begin
			case (off.gen.block)
				`BLK_UART:
					if (off.gen.word == 3'd0) rsp.prdata = {24'd0, rxData};
					else if (off.gen.word == 3'd1) rsp.prdata = {27'd0, pwmPeriod,
						flags.rxOverrun, flags.rxFrameErr, flags.txRdy, flags.rxValid};
				`BLK_PWM:   if (off.gen.word == 3'd0) rsp.prdata = {28'd0, gpin};
				`BLK_TIMER: if (off.gen.word == 3'd0) rsp.prdata = 32'(timer);
				`BLK_IRQ:
					if (!off.irq.isVector && off.irq.vecIdx == 2'd0) rsp.prdata = {29'd0, enable};
				default: rsp.prdata = '0;
			endcase
		end
	end

	// Free-running timer
	always_ff @(posedge clk or posedge reset) begin
		if (reset) timer <= '0;
		else timer <= timer + 1'b1;
	end

	//////////////////////
	// Peers

	uartCore i_uartCore (
		.clk, .reset,
		.txData(req.pwdata[7:0]), .txWrite, .rxRead,
		.rxData, .flags, .rxd, .txd
	);

	pwmUnit i_pwmUnit (
		.clk, .reset,
		.duty(req.pwdata[7:0]), .dutyWrite, .pwmOut, .pwmPeriod
	);

	assign sources.rxValid   = flags.rxValid;
	assign sources.txRdy     = flags.txRdy;
	assign sources.pwmPeriod = pwmPeriod;

	irqCtrl i_irqCtrl (
		.clk, .reset,
		.wdata(req.pwdata), .irqEnWrite, .vecWrite, .vecIndex(off.irq.vecIdx),
		.sources, .enable, .irq, .irqVector
	);

endmodule

// File: dv/periph_sva.sv
`timescale 1ns/1ps

// APB handshake, UART line and interrupt checks for periphTop
module periphSva import apbPkg::*, periphPkg::*; (
	input logic      clk,
	input logic      reset,
	input apbReq     req,
	input apbRsp     rsp,
	input logic      txd,
	input uartFlags  flags,
	input logic      pwmPeriod,
	input logic      irq,
	input irqSources enable
);

	//////////////////////
	// Properties

	// Completed transmit write drops txRdy and sends the start bit next cycle
	property txWriteStarts;
		@(posedge clk) disable iff (reset)
			req.psel && req.penable && rsp.pready && req.pwrite && req.paddr == 8'h00
			|=> !flags.txRdy && !txd;
	endproperty

	// Idle transmitter holds the line high
	property idleLineHigh;
		@(posedge clk) disable iff (reset) flags.txRdy |-> txd;
	endproperty

	// Request needs at least one enabled flag among rxValid, txRdy and pwmPeriod
	property irqHasSource;
		@(posedge clk) disable iff (reset)
			irq |-> ((enable & {pwmPeriod, flags.txRdy, flags.rxValid}) != 3'b000);
	endproperty

	apTxStart: assert property (txWriteStarts) else $error("transmit write did not start a frame");
	apLine:    assert property (idleLineHigh) else $error("txd low while transmitter idle");
	apIrq:     assert property (irqHasSource) else $error("irq high with no enabled source");

endmodule

bind periphTop periphSva i_periphSva (
	.clk, .reset, .req, .rsp, .txd, .flags, .pwmPeriod, .irq, .enable
);

// File: dv/tbPeriph.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

module tbPeriph import apbPkg::*; ();

	typedef enum logic [3:0] {
		OP_WRITE, OP_READ, OP_POLL, OP_WAITIRQ, OP_PINS, OP_PWM, OP_SYNC, OP_GPIN, OP_TIMER
	} opKind;

	// One row of the stimulus table
	typedef struct packed {
		opKind       op;
		logic [7:0]  offset;
		logic [31:0] wdata;
		logic [31:0] expVal;    // Pins rows: {irqVector, irq, pwmOut}
		logic [31:0] mask;
	} stepEntry;

	localparam logic [31:0] vec1 = 32'h0000_1100;    // Low two bits are not stored
	localparam logic [31:0] vec2 = 32'h0000_2200;
	localparam logic [31:0] vec3 = 32'h0000_3300;

	logic        clk = 1'b0;
	logic        reset;
	apbReq       req;
	apbRsp       rsp;
	logic        rxd;
	logic        txd;
	logic [3:0]  gpin;
	logic        pwmOut;
	logic        irq;
	logic [29:0] irqVector;
	stepEntry    steps[$];
	string       names[$];
	integer      seed;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          limit = 32'h7fff_ffff;

	always #10 clk = ~clk;    // 20 ns period

	assign rxd = txd;    // UART loopback

	periphTop i_periphTop (
		.clk, .reset, .req, .rsp, .rxd, .txd, .gpin, .pwmOut, .irq, .irqVector
	);

	//////////////////////
	// APB master

	task automatic apbTransfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		@(negedge clk);    // Setup
		req.psel    = 1'b1;
		req.penable = 1'b0;
		req.pwrite  = wr;
		req.paddr   = addr;
		req.pwdata  = wdata;
		@(negedge clk);
		req.penable = 1'b1;
		do @(posedge clk); while (!rsp.pready);    // Completing edge
		rdata = rsp.prdata;
		@(negedge clk);
		req.psel    = 1'b0;
		req.penable = 1'b0;
	endtask

	//////////////////////
	// Stimulus table

	task automatic addStep(input string name, input opKind op, input logic [7:0] offset,
		input logic [31:0] wdata, input logic [31:0] expVal, input logic [31:0] mask);
		names.push_back(name);
		steps.push_back(stepEntry'{op, offset, wdata, expVal, mask});
	endtask

	task automatic buildTable();
		// Reset state, pwmPeriod masked since the counter hits 0 right away
		addStep("rstStatus", OP_READ, 8'h04, 0, 32'h02, 32'h0F);
		addStep("rstMask", OP_READ, 8'hE0, 0, 32'h0, 32'h7);
		addStep("rstPins", OP_PINS, 8'h00, 0, 32'h0, 32'h3);
		addStep("unmapped", OP_READ, 8'h40, 0, 32'h0, 32'hFFFF_FFFF);
		// Loopback, the read stalls until the byte is back
		addStep("lbTx0", OP_WRITE, 8'h00, 32'hA5, 0, 0);
		addStep("lbRx0", OP_READ, 8'h00, 0, 32'hA5, 32'hFF);
		addStep("lbStat0", OP_READ, 8'h04, 0, 32'h0, 32'h05);    // No frame error, drained
		addStep("lbTx1", OP_WRITE, 8'h00, 32'h3C, 0, 0);
		addStep("lbRx1", OP_READ, 8'h00, 0, 32'h3C, 32'hFF);
		addStep("lbStat1", OP_READ, 8'h04, 0, 32'h0, 32'h05);
		// Overrun
		addStep("ovTx0", OP_WRITE, 8'h00, 32'h11, 0, 0);
		addStep("ovTx1", OP_WRITE, 8'h00, 32'h96, 0, 0);
		addStep("ovPoll", OP_POLL, 8'h04, 0, 32'h08, 32'h08);
		addStep("ovRx", OP_READ, 8'h00, 0, 32'h96, 32'hFF);
		addStep("ovStat", OP_READ, 8'h04, 0, 32'h0, 32'h09);
		// PWM duty, expected value is the high cycle count
		addStep("pwmDuty0", OP_WRITE, 8'h20, 32'd0, 0, 0);
		addStep("pwmHigh0", OP_PWM, 8'h00, 0, 32'd0, 32'hFF);
		addStep("pwmDuty60", OP_WRITE, 8'h20, 32'd60, 0, 0);
		addStep("pwmHigh60", OP_PWM, 8'h00, 0, 32'd60, 32'hFF);
		addStep("pwmDuty180", OP_WRITE, 8'h20, 32'd180, 0, 0);
		addStep("pwmHigh180", OP_PWM, 8'h00, 0, 32'd180, 32'hFF);
		// Interrupts, rx and PWM enabled
		addStep("irqVec1", OP_WRITE, 8'hF4, vec1, 0, 0);
		addStep("irqVec2", OP_WRITE, 8'hF8, vec2, 0, 0);
		addStep("irqVec3", OP_WRITE, 8'hFC, vec3, 0, 0);
		addStep("irqMask", OP_WRITE, 8'hE0, 32'h5, 0, 0);
		addStep("irqMaskRd", OP_READ, 8'hE0, 0, 32'h5, 32'h7);
		addStep("irqWait", OP_WAITIRQ, 8'h00, 0, 0, 0);
		addStep("irqPwm", OP_PINS, 8'h00, 0, vec3 | 32'h2, 32'hFFFF_FFFE);
		addStep("irqTx", OP_WRITE, 8'h00, 32'h5A, 0, 0);
		addStep("irqRxPoll", OP_POLL, 8'h04, 0, 32'h01, 32'h01);
		addStep("irqRxVec", OP_PINS, 8'h00, 0, vec1 | 32'h2, 32'hFFFF_FFFE);
		addStep("irqRx", OP_READ, 8'h00, 0, 32'h5A, 32'hFF);
		addStep("irqBack", OP_PINS, 8'h00, 0, vec3 | 32'h2, 32'hFFFF_FFFE);
		addStep("irqSync", OP_SYNC, 8'h00, 0, 0, 0);    // Keeps the write off count 0
		addStep("irqDuty", OP_WRITE, 8'h20, 32'd90, 0, 0);
		addStep("irqClear", OP_PINS, 8'h00, 0, 32'h0, 32'h2);
		// Read-only registers
		addStep("gpin0", OP_GPIN, 8'h20, 0, 0, 32'hFFFF_FFFF);
		addStep("gpin1", OP_GPIN, 8'h20, 0, 0, 32'hFFFF_FFFF);
		addStep("timerInc", OP_TIMER, 8'h60, 0, 0, 0);
	endtask

	//////////////////////
	// Step execution

	task automatic runStep(input string name, input stepEntry s);
		logic [31:0] act;
		logic [31:0] expv;
		logic [31:0] first;
		int          highs;
		bit          compare;
		act     = '0;
		expv    = s.expVal;
		compare = 1'b1;
		case (s.op)
			OP_WRITE: begin
				apbTransfer(1'b1, s.offset, s.wdata, act);
				compare = 1'b0;
			end
			OP_READ: apbTransfer(1'b0, s.offset, '0, act);
			OP_POLL: begin
				do apbTransfer(1'b0, s.offset, '0, act);
				while ((act & s.mask) != (expv & s.mask));    // Watchdog ends a stuck poll
			end
			OP_WAITIRQ: begin
				while (!irq) @(negedge clk);
				compare = 1'b0;
			end
			OP_PINS: begin
				@(negedge clk);
				act = {irqVector, irq, pwmOut};
			end
			OP_PWM: begin
				repeat (2 * (`PWM_TOP + 1)) @(negedge clk);    // New duty in the buffer
				highs = 0;
				repeat (`PWM_TOP + 1) begin
					@(negedge clk);
					if (pwmOut) highs++;
				end
				act = highs;
			end
			OP_SYNC: begin
				// Wait for a rising pwmOut, count just left 0
				do @(negedge clk); while (pwmOut);
				do @(negedge clk); while (!pwmOut);
				compare = 1'b0;
			end
			OP_GPIN: begin
				@(negedge clk);
				gpin = 4'($random(seed));
				expv = {28'd0, gpin};
				apbTransfer(1'b0, s.offset, '0, act);
			end
			OP_TIMER: begin
				apbTransfer(1'b0, s.offset, '0, first);
				apbTransfer(1'b0, s.offset, '0, act);
				compare = 1'b0;
				checks++;
				if (act <= first) begin
					errors++;
					$display("FAIL %s expected above 0x%08h actual 0x%08h", name, first, act);
				end
			end
			default: compare = 1'b0;
		endcase
		if (compare) begin
			checks++;
			if ((act & s.mask) !== (expv & s.mask)) begin
				errors++;
				$display("FAIL %s expected 0x%08h actual 0x%08h", name, expv & s.mask,
					act & s.mask);
			end
		end
	endtask

	//////////////////////
	// Watchdog

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("Checks %0d, errors %0d", checks, errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		seed   = 32'hd04d;
		req    = '0;
		gpin   = 4'($random(seed));
		reset  = 1'b1;
		buildTable();
		// Bytes, PWM periods and table rows, plus half again
		limit = 3 * (12 * 10 * `UART_DIVIDER + 6 * (`PWM_TOP + 1) + 2 * steps.size()) / 2;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		foreach (steps[i]) runStep(names[i], steps[i]);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) $display("TEST OK");
		else $display("TEST FAILED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+hw
hw/apbPkg.sv
hw/periphPkg.sv
hw/uartCore.sv
hw/pwmUnit.sv
hw/irqCtrl.sv
hw/periphTop.sv
dv/periph_sva.sv
dv/tbPeriph.sv
